// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= decode_stage_tb
FILELIST ?= decode_stage.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

# The run passes only if the pass message shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== arm_decode_pkg.sv ====
`default_nettype none

package arm_decode_pkg;

	typedef logic [3:0] reg_num;

	localparam reg_num r14 = 4'd14; // Link register.
	localparam reg_num r15 = 4'd15;

	// Same order as the opcode field in bits 24:21.
	typedef enum logic [3:0] {
		alu_and, alu_eor, alu_sub, alu_rsb,
		alu_add, alu_adc, alu_sbc, alu_rsc,
		alu_tst, alu_teq, alu_cmp, alu_cmn,
		alu_orr, alu_mov, alu_bic, alu_mvn
	} alu_op;

	typedef enum logic [3:0] {
		grp_branch,
		grp_mul,
		grp_ldst_misc,
		grp_alu,
		grp_ldst_single,
		grp_ldst_mult,
		grp_coproc,
		grp_mrs,
		grp_msr,
		grp_undef
	} insn_group;

	typedef struct packed {
		alu_op  op;
		reg_num rd;
		reg_num rn;
		logic   uses_rn;
	} data_decode;

	typedef struct packed {
		logic [11:0] imm;
		reg_num      r;
		logic [4:0]  shift_imm;
		logic        is_imm;
		logic        shr;
		logic        ror;
		logic        shift_by_reg;
	} snd_decode;

	typedef struct packed {
		logic        load;
		logic        writeback;
		logic        pre_index;
		logic        increment;
		logic [15:0] reg_list;
	} ldst_decode;

	typedef struct packed {
		logic       execute;
		logic       undefined;
		logic       branch;
		logic       ldst;
		logic       mul;
		logic       psr;
		logic       coproc;
		logic       writeback;
		logic       update_flags;
		logic       conditional;
		logic       restore_spsr;
		logic       psr_saved;
		logic       psr_write;
		logic       psr_wr_flags;
		logic       psr_wr_control;
		data_decode data;
		snd_decode  snd;
		ldst_decode ldst_fields;
		reg_num     uop_reg;
		logic [5:0] uop_offset;
	} decode_bundle;

	// Order of the tests matters, later ones rely on earlier exclusions.
	function automatic insn_group group_of(logic [31:0] insn);
		logic [7:0] op;
		logic [3:0] lo;
		op = insn[27:20];
		lo = insn[7:4];
		if (op[7:5] == 3'b101)
			return grp_branch;
		if (op[7:2] == 6'b000000 && lo == 4'b1001)
			return grp_mul;
		if (op[7:5] == 3'b000 && lo[3] && lo[0])
			return (lo[2:1] != 2'b00) ? grp_ldst_misc : grp_undef; // Swap lands here.
		if (op[7:6] == 2'b00 && op[4:3] == 2'b10 && !op[0]) begin
			if (!op[1] && !op[5] && lo == 4'b0000)
				return grp_mrs;
			if (op[1] && (op[5] || lo == 4'b0000))
				return grp_msr;
			return grp_undef;
		end
		if (op[7:6] == 2'b00)
			return grp_alu;
		if (op[7:6] == 2'b01)
			return (op[5] && lo[0]) ? grp_undef : grp_ldst_single;
		if (op[7:5] == 3'b100)
			return grp_ldst_mult;
		if (op[7:6] == 2'b11 && op[5:4] != 2'b11)
			return grp_coproc; // 1111 is SWI.
		return grp_undef;
	endfunction

endpackage

`default_nettype wire

// ==== decode_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_alu (
	input  wire logic [31:0]              insn,
	output arm_decode_pkg::data_decode    data,
	output arm_decode_pkg::snd_decode     snd,
	output logic                          snd_undefined, data_writeback, data_conditional,
	output logic                          data_update_flags, data_restore_spsr, data_is_imm,
	output logic                          mul_update_flags,
	output arm_decode_pkg::reg_num        mul_rd, mul_rs, mul_rm,
	output logic                          msr_spsr, msr_is_imm, msr_fields_f, msr_fields_c,
	output logic                          mrs_spsr,
	output arm_decode_pkg::reg_num        mrs_rd,
	output logic                          coproc_load,
	output arm_decode_pkg::reg_num        coproc_rd
);

	arm_decode_pkg::insn_group grp;

	assign grp = arm_decode_pkg::group_of(insn);

	assign data.op = arm_decode_pkg::alu_op'(insn[24:21]);
	assign data.rd = insn[15:12];
	assign data.rn = insn[19:16];
	assign data.uses_rn = !(data.op inside {arm_decode_pkg::alu_mov, arm_decode_pkg::alu_mvn});

	assign data_writeback = data.op[3:2] != 2'b10; // Compares only set flags.
	assign data_update_flags = insn[20];
	assign data_conditional = insn[31:28] != 4'b1110;
	assign data_restore_spsr = insn[20] && data.rd == arm_decode_pkg::r15 && data_writeback;
	assign data_is_imm = insn[25];

	always_comb begin
		snd = '0;
		snd.r = insn[3:0];
		snd.is_imm = insn[25];
		if (insn[25]) begin
			snd.imm = {4'b0000, insn[7:0]};
			snd.shift_imm = {insn[11:8], 1'b0}; // Rotate by twice the field.
			snd.ror = 1'b1;
		end else begin
			{snd.ror, snd.shr} = insn[6:5]; // lsl, lsr, asr, ror.
			snd.shift_by_reg = insn[4];
			if (insn[4])
				snd.imm = {8'h00, insn[11:8]}; // Shift amount register.
			else
				snd.shift_imm = insn[11:7];
		end
	end

	// PC as shift or operand register with a register shift.
	assign snd_undefined = grp == arm_decode_pkg::grp_alu && !insn[25] && insn[4] &&
		(insn[11:8] == arm_decode_pkg::r15 || insn[3:0] == arm_decode_pkg::r15);

	assign mul_update_flags = insn[20];
	assign mul_rd = insn[19:16];
	assign mul_rs = insn[11:8];
	assign mul_rm = insn[3:0];

	assign msr_spsr = insn[22];
	assign msr_is_imm = insn[25];
	assign msr_fields_f = insn[19];
	assign msr_fields_c = insn[16];
	assign mrs_spsr = insn[22];
	assign mrs_rd = insn[15:12];

	assign coproc_load = insn[20];
	assign coproc_rd = insn[15:12];

endmodule

`default_nettype wire

// ==== decode_ldst.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_ldst (
	input  wire logic [31:0]           insn,
	output arm_decode_pkg::ldst_decode ldst_single,
	output arm_decode_pkg::ldst_decode ldst_misc,
	output arm_decode_pkg::ldst_decode ldst_multiple,
	output logic                       ldst_single_is_imm,
	output logic                       ldst_misc_off_is_imm,
	output arm_decode_pkg::reg_num     ldst_misc_off_reg,
	output logic [7:0]                 ldst_misc_off_imm,
	output logic                       ldst_mult_restore_spsr,
	output arm_decode_pkg::data_decode data_ldst
);

	arm_decode_pkg::insn_group grp;

	assign grp = arm_decode_pkg::group_of(insn);

	// P, U, W and L sit in the same bits for all three forms.
	always_comb begin
		ldst_single = '0;
		ldst_single.load = insn[20];
		ldst_single.writeback = insn[21];
		ldst_single.increment = insn[23];
		ldst_single.pre_index = insn[24];

		ldst_misc = ldst_single;

		ldst_multiple = ldst_single;
		ldst_multiple.reg_list = insn[15:0];
	end

	assign ldst_single_is_imm = !insn[25]; // I bit is inverted here.

	assign ldst_misc_off_is_imm = insn[22];
	assign ldst_misc_off_reg = insn[3:0];
	assign ldst_misc_off_imm = {insn[11:8], insn[3:0]};

	// S bit with PC in the list on a load.
	assign ldst_mult_restore_spsr = insn[22] && insn[20] && insn[15];

	// Base plus or minus offset.
	always_comb begin
		data_ldst.op = insn[23] ? arm_decode_pkg::alu_add : arm_decode_pkg::alu_sub;
		data_ldst.rn = insn[19:16];
		data_ldst.uses_rn = 1'b1;
		if (grp == arm_decode_pkg::grp_ldst_mult)
			data_ldst.rd = insn[19:16]; // Updated base.
		else
			data_ldst.rd = insn[15:12];
	end

endmodule

`default_nettype wire

// ==== decode_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_mux (
	input  wire logic [31:0]              insn,
	input  wire logic                     branch_link,
	input  wire arm_decode_pkg::data_decode data,
	input  wire arm_decode_pkg::snd_decode  snd,
	input  wire logic                     snd_undefined, data_writeback, data_conditional,
	input  wire logic                     data_update_flags, data_restore_spsr, data_is_imm,
	input  wire logic                     mul_update_flags,
	input  wire arm_decode_pkg::reg_num   mul_rd, mul_rs, mul_rm,
	input  wire logic                     msr_spsr, msr_is_imm, msr_fields_f, msr_fields_c,
	input  wire logic                     mrs_spsr,
	input  wire arm_decode_pkg::reg_num   mrs_rd,
	input  wire logic                     coproc_load,
	input  wire arm_decode_pkg::reg_num   coproc_rd,
	input  wire arm_decode_pkg::ldst_decode ldst_single, ldst_misc, ldst_multiple,
	input  wire logic                     ldst_single_is_imm, ldst_misc_off_is_imm,
	input  wire arm_decode_pkg::reg_num   ldst_misc_off_reg,
	input  wire logic [7:0]               ldst_misc_off_imm,
	input  wire logic                     ldst_mult_restore_spsr,
	input  wire arm_decode_pkg::data_decode data_ldst,
	output arm_decode_pkg::decode_bundle  bundle,
	output logic                          is_ldm
);

	arm_decode_pkg::insn_group grp;

	assign grp = arm_decode_pkg::group_of(insn);

	always_comb begin
		bundle = '0;
		bundle.execute = 1'b1;
		bundle.data.uses_rn = 1'b1;
		bundle.snd.is_imm = 1'b1;
		bundle.psr_wr_flags = 1'b1;
		bundle.psr_wr_control = 1'b1;

		case (grp)
			arm_decode_pkg::grp_branch: begin
				bundle.branch = 1'b1;
				bundle.data.uses_rn = branch_link;
				if (branch_link) begin
					bundle.data.op = arm_decode_pkg::alu_sub; // lr = pc - 4.
					bundle.data.rd = arm_decode_pkg::r14;
					bundle.data.rn = arm_decode_pkg::r15;
					bundle.snd.imm = 12'd4;
					bundle.writeback = 1'b1;
				end
			end
			arm_decode_pkg::grp_mul: begin
				bundle.mul = 1'b1;
				bundle.data.rd = mul_rd;
				bundle.data.rn = mul_rs;
				bundle.snd.is_imm = 1'b0;
				bundle.snd.r = mul_rm;
				bundle.writeback = 1'b1;
				bundle.update_flags = mul_update_flags;
			end
			arm_decode_pkg::grp_ldst_misc: begin
				bundle.ldst_fields = ldst_misc;
				bundle.snd.r = ldst_misc_off_reg;
				bundle.snd.imm = {4'b0000, ldst_misc_off_imm};
				bundle.snd.is_imm = ldst_misc_off_is_imm;
			end
			arm_decode_pkg::grp_alu: begin
				bundle.data = data;
				bundle.snd = snd;
				bundle.snd.is_imm = data_is_imm;
				bundle.writeback = data_writeback;
				bundle.update_flags = data_update_flags;
				bundle.restore_spsr = data_restore_spsr;
				bundle.conditional = data_conditional;
				bundle.undefined = snd_undefined;
			end
			arm_decode_pkg::grp_ldst_single: begin
				bundle.ldst_fields = ldst_single;
				bundle.snd.is_imm = ldst_single_is_imm;
				if (ldst_single_is_imm) begin
					bundle.snd.imm = insn[11:0]; // Unrotated 12-bit offset.
				end else begin
					bundle.snd.r = insn[3:0];
					bundle.snd.shift_imm = insn[11:7];
					{bundle.snd.ror, bundle.snd.shr} = insn[6:5];
				end
			end
			arm_decode_pkg::grp_ldst_mult: begin
				bundle.ldst_fields = ldst_multiple;
				bundle.snd.imm = 12'd4;
				bundle.restore_spsr = ldst_mult_restore_spsr;
				bundle.undefined = ldst_multiple.reg_list == '0;
			end
			arm_decode_pkg::grp_coproc: begin
				bundle.coproc = 1'b1;
				bundle.data.op = arm_decode_pkg::alu_mov;
				bundle.data.rd = coproc_rd;
				bundle.data.rn = coproc_rd;
				bundle.data.uses_rn = !coproc_load; // Stores read the register.
				bundle.writeback = coproc_load;
			end
			arm_decode_pkg::grp_mrs: begin
				bundle.data.rd = mrs_rd;
				bundle.data.uses_rn = 1'b0;
				bundle.psr = 1'b1;
				bundle.psr_saved = mrs_spsr;
				bundle.writeback = 1'b1;
				bundle.conditional = 1'b1;
			end
			arm_decode_pkg::grp_msr: begin
				bundle.data.uses_rn = 1'b0;
				bundle.snd = snd;
				bundle.snd.is_imm = msr_is_imm;
				bundle.psr = 1'b1;
				bundle.psr_write = 1'b1;
				bundle.psr_saved = msr_spsr;
				bundle.conditional = 1'b1;
				bundle.psr_wr_flags = msr_fields_f;
				bundle.psr_wr_control = msr_fields_c;
			end
			default:
				bundle.undefined = 1'b1;
		endcase

		// Address goes through the ALU for every load/store form.
		if (grp inside {arm_decode_pkg::grp_ldst_single, arm_decode_pkg::grp_ldst_misc,
				arm_decode_pkg::grp_ldst_mult}) begin
			bundle.ldst = 1'b1;
			bundle.data = data_ldst;
			bundle.writeback = bundle.ldst_fields.writeback || bundle.ldst_fields.load;
		end

		if (bundle.undefined) begin
			bundle.execute = 1'b0;
			bundle.writeback = 1'b0;
		end
	end

	assign is_ldm = grp == arm_decode_pkg::grp_ldst_mult && !bundle.undefined;

endmodule

`default_nettype wire

// ==== decode_stage.f ====
arm_decode_pkg.sv
decode_alu.sv
decode_ldst.sv
decode_mux.sv
reglist_counter.sv
ldm_sequencer.sv
decode_stage.sv
decode_stage_assertions.sv
decode_stage_tb.sv

// ==== decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic [31:0]             insn,
	input  wire logic                    insn_valid,
	output logic                         stall,
	output logic                         out_valid,
	output arm_decode_pkg::decode_bundle out
);

	arm_decode_pkg::data_decode data, data_ldst;
	arm_decode_pkg::snd_decode snd;
	arm_decode_pkg::ldst_decode ldst_single, ldst_misc, ldst_multiple;
	arm_decode_pkg::reg_num mul_rd, mul_rs, mul_rm, mrs_rd, coproc_rd, ldst_misc_off_reg;
	arm_decode_pkg::reg_num cur_reg;
	arm_decode_pkg::decode_bundle bundle, bundle_q;
	logic snd_undefined, data_writeback, data_conditional, data_update_flags;
	logic data_restore_spsr, data_is_imm, mul_update_flags;
	logic msr_spsr, msr_is_imm, msr_fields_f, msr_fields_c, mrs_spsr, coproc_load;
	logic ldst_single_is_imm, ldst_misc_off_is_imm, ldst_mult_restore_spsr;
	logic [7:0] ldst_misc_off_imm;
	logic [5:0] offset;
	logic branch_link, is_ldm, accept;
	logic load, step, uop_valid, last, valid_q;

	assign accept = insn_valid && !stall;
	assign branch_link = insn[24];

	// Decoder and mux ports share their names with the nets here.
	decode_alu decode_alu_i (.*);
	decode_ldst decode_ldst_i (.*);
	decode_mux decode_mux_i (.*);

	ldm_sequencer ldm_sequencer_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.accept    (accept),
		.is_ldm    (is_ldm),
		.last      (last),
		.load      (load),
		.step      (step),
		.uop_valid (uop_valid),
		.stall     (stall)
	);

	reglist_counter reglist_counter_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.load     (load),
		.step     (step),
		.reg_list (bundle.ldst_fields.reg_list),
		.cur_reg  (cur_reg),
		.offset   (offset),
		.last     (last)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= accept && !is_ldm; // Multiples report through uop_valid.
	end

	// Held through the expansion since stall blocks accept.
	always_ff @(posedge clk) begin
		if (accept)
			bundle_q <= bundle;
	end

	always_comb begin
		out = bundle_q;
		if (uop_valid) begin
			out.uop_reg = cur_reg;
			out.uop_offset = offset;
		end
	end

	assign out_valid = valid_q || uop_valid;

endmodule

`default_nettype wire

// ==== decode_stage_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage_assertions (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic accept,
	input wire logic is_ldm,
	input wire logic stall,
	input wire logic out_valid
);

	int failures = 0;

	// Stall only follows an accepted load/store multiple.
	stall_after_ldm: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(stall) |-> $past(accept && is_ldm))
	else begin
		$error("stall rose without an accepted load/store multiple");
		failures++;
	end

	idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid && !stall)
	else begin
		$error("out_valid or stall high right after reset");
		failures++;
	end

	// Every stalled cycle carries a micro-op, and one more follows it.
	valid_during_stall: assert property (@(posedge clk) disable iff (!arst_n)
		stall |-> out_valid ##1 out_valid)
	else begin
		$error("stall high without a micro-op in this cycle and the next");
		failures++;
	end

endmodule

bind decode_stage decode_stage_assertions decode_stage_assertions_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.accept    (accept),
	.is_ldm    (is_ldm),
	.stall     (stall),
	.out_valid (out_valid)
);

`default_nettype wire

// ==== decode_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage_tb;

	typedef struct packed {
		logic [31:0] insn;
		logic        execute;
		logic        undefined;
		logic        branch;
		logic        ldst;
		logic        mul;
		logic        psr;
		logic        coproc;
		logic        writeback;
		logic        update_flags;
		logic        psr_write;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  rn;
		logic        uses_rn;
		logic [4:0]  uops;
	} vector_t;

	logic clk = 1'b0;
	logic arst_n;
	logic [31:0] insn;
	logic insn_valid;
	logic stall;
	logic out_valid;
	arm_decode_pkg::decode_bundle out;

	vector_t vectors[$];
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int limit = 0;
	int assert_fails = 0;
	bit file_ok;

	decode_stage dut_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn       (insn),
		.insn_valid (insn_valid),
		.stall      (stall),
		.out_valid  (out_valid),
		.out        (out)
	);

	always #5 clk = ~clk;

	// Limit stays zero until the vectors are loaded.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout reached after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic read_vectors(output bit ok);
		int fd;
		int n;
		string line;
		logic [31:0] f [16];
		vector_t v;
		ok = 1'b0;
		fd = $fopen("decode_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open decode_vectors.txt");
		end else begin
			ok = 1'b1;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 8 && line[0] != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
						f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
					if (n != 16) begin
						$display("Malformed line in decode_vectors.txt: %s", line);
						ok = 1'b0;
					end else begin
						v.insn = f[0];
						v.execute = f[1][0];
						v.undefined = f[2][0];
						v.branch = f[3][0];
						v.ldst = f[4][0];
						v.mul = f[5][0];
						v.psr = f[6][0];
						v.coproc = f[7][0];
						v.writeback = f[8][0];
						v.update_flags = f[9][0];
						v.psr_write = f[10][0];
						v.op = f[11][3:0];
						v.rd = f[12][3:0];
						v.rn = f[13][3:0];
						v.uses_rn = f[14][0];
						v.uops = f[15][4:0];
						vectors.push_back(v);
					end
				end
			end
			$fclose(fd);
			if (vectors.size() == 0) begin
				$display("No vectors found in decode_vectors.txt");
				ok = 1'b0;
			end
		end
	endtask

	// Undefined words only promise the two status flags.
	task automatic check_fields(input vector_t v);
		check("out.execute", 32'(out.execute), 32'(v.execute));
		check("out.undefined", 32'(out.undefined), 32'(v.undefined));
		if (!v.undefined) begin
			check("out.branch", 32'(out.branch), 32'(v.branch));
			check("out.ldst", 32'(out.ldst), 32'(v.ldst));
			check("out.mul", 32'(out.mul), 32'(v.mul));
			check("out.psr", 32'(out.psr), 32'(v.psr));
			check("out.coproc", 32'(out.coproc), 32'(v.coproc));
			check("out.writeback", 32'(out.writeback), 32'(v.writeback));
			check("out.update_flags", 32'(out.update_flags), 32'(v.update_flags));
			check("out.psr_write", 32'(out.psr_write), 32'(v.psr_write));
			check("out.data.op", 32'(out.data.op), 32'(v.op));
			check("out.data.rd", 32'(out.data.rd), 32'(v.rd));
			check("out.data.rn", 32'(out.data.rn), 32'(v.rn));
			check("out.data.uses_rn", 32'(out.data.uses_rn), 32'(v.uses_rn));
		end
	endtask

	task automatic apply_vector(input vector_t v);
		logic [3:0] regs[$];
		@(posedge clk);
		#1;
		while (stall) begin
			@(posedge clk);
			#1;
		end
		insn = v.insn;
		insn_valid = 1'b1;
		@(posedge clk); // Accept edge.
		#1;
		insn_valid = 1'b0;
		@(negedge clk);
		check("out_valid", 32'(out_valid), 32'd1);
		check_fields(v);
		if (v.uops == 0) begin
			check("stall", 32'(stall), 32'd0);
		end else begin
			// Registers leave in ascending order.
			for (int r = 0; r < 16; r++) begin
				if (v.insn[r])
					regs.push_back(4'(r));
			end
			check("micro-op count", 32'(regs.size()), 32'(v.uops));
			for (int i = 0; i < regs.size(); i++) begin
				if (i > 0) begin
					@(negedge clk);
					check("out_valid", 32'(out_valid), 32'd1);
				end
				check("out.uop_reg", 32'(out.uop_reg), 32'(regs[i]));
				check("out.uop_offset", 32'(out.uop_offset), 32'(4 * i));
				check("stall", 32'(stall), 32'(i < regs.size() - 1));
			end
		end
		@(negedge clk);
		check("out_valid", 32'(out_valid), 32'd0);
	endtask

	initial begin
		arst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		read_vectors(file_ok);
		if (!file_ok) begin
			$display("TEST FAILED");
			$finish;
		end else begin
			foreach (vectors[i])
				limit += 20 + int'(vectors[i].uops);
			repeat (4) @(posedge clk);
			#1;
			arst_n = 1'b1;
			@(negedge clk);
			check("out_valid", 32'(out_valid), 32'd0);
			check("stall", 32'(stall), 32'd0);
			foreach (vectors[i])
				apply_vector(vectors[i]);
			assert_fails = dut_i.decode_stage_assertions_i.failures;
			$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
				assert_fails);
			if (errors == 0 && assert_fails == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== decode_vectors.txt ====
# insn exec undef branch ldst mul psr coproc wb upd_flags psr_write op rd rn uses_rn uops
# All columns hex. Undefined rows only check exec and undef.
E2821005 1 0 0 0 0 0 0 1 0 0 4 1 2 1 0
E1B03004 1 0 0 0 0 0 0 1 1 0 d 3 0 0 0
E3550001 1 0 0 0 0 0 0 0 1 0 a 0 5 1 0
E0476918 1 0 0 0 0 0 0 1 0 0 2 6 7 1 0
E0876F18 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
EA000002 1 0 1 0 0 0 0 0 0 0 0 0 0 0 0
EB000010 1 0 1 0 0 0 0 1 0 0 2 e f 1 0
E0110392 1 0 0 0 1 0 0 1 1 0 0 1 3 1 0
E5910004 1 0 0 1 0 0 0 1 0 0 4 0 1 1 0
E4032008 1 0 0 1 0 0 0 0 0 0 2 2 3 1 0
E5A32008 1 0 0 1 0 0 0 1 0 0 4 2 3 1 0
E1D540B2 1 0 0 1 0 0 0 1 0 0 4 4 5 1 0
E00760B8 1 0 0 1 0 0 0 0 0 0 2 6 7 1 0
E1012093 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
E8B0002A 1 0 0 1 0 0 0 1 0 0 4 0 0 1 3
E92D4010 1 0 0 1 0 0 0 1 0 0 2 d d 1 2
E8920080 1 0 0 1 0 0 0 1 0 0 4 2 2 1 1
E89DFFFF 1 0 0 1 0 0 0 1 0 0 4 d d 1 10
E8900000 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
E10F3000 1 0 0 0 0 1 0 1 0 0 0 3 0 0 0
E328F20F 1 0 0 0 0 1 0 0 0 1 0 0 0 0 0
E169F001 1 0 0 0 0 1 0 0 0 1 0 0 0 0 0
ED931000 1 0 0 0 0 0 1 1 0 0 d 1 1 0 0
EF000000 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== ldm_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ldm_sequencer (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic accept,
	input  wire logic is_ldm,
	input  wire logic last,
	output logic      load,
	output logic      step,
	output logic      uop_valid,
	output logic      stall
);

	typedef enum logic [1:0] {
		idle,
		issue,
		done
	} state_t;

	state_t state, state_next;

	// Accept only happens with stall low, so load never cuts an expansion short.
	assign load = accept && is_ldm;
	assign uop_valid = state == issue;
	assign step = uop_valid;
	assign stall = uop_valid && !last; // Fetch may proceed during the last micro-op.

	always_comb begin
		state_next = state;
		case (state)
			idle, done:
				state_next = load ? issue : idle;
			issue: begin
				// Back-to-back multiple reloads straight away.
				if (last)
					state_next = load ? issue : done;
			end
			default:
				state_next = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= idle;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// ==== reglist_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module reglist_counter (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              load,
	input  wire logic              step,
	input  wire logic [15:0]       reg_list,
	output arm_decode_pkg::reg_num cur_reg,
	output logic [5:0]             offset,
	output logic                   last
);

	logic [15:0] remaining;

	// Lowest set register goes first.
	always_comb begin
		cur_reg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (remaining[i])
				cur_reg = 4'(i);
		end
	end

	assign last = (remaining & (remaining - 16'd1)) == '0; // At most one bit left.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			remaining <= '0;
			offset <= '0;
		end else if (load) begin
			remaining <= reg_list;
			offset <= '0;
		end else if (step) begin
			remaining[cur_reg] <= 1'b0;
			offset <= offset + 6'd4; // One word per register.
		end
	end

endmodule

`default_nettype wire
